/* src.f */
+incdir+src
src/fround_bus_pkg.sv
src/fround_video_pkg.sv
src/fround_ctrl_regs.sv
src/fround_video_timing.sv
src/fround_scroll_addr.sv
src/fround_debug_view.sv
src/fround_game.sv
test/fround_checker.sv
test/fround_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= fround_tb
FILELIST ?= src.f
BUILD    ?= obj_dir
LOG      ?= sim.log

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/fround_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fround_defines.svh"

module fround_tb;

    import fround_bus_pkg::*;
    import fround_video_pkg::*;

    // One frame of pixel enables at half the clock rate
    localparam int FRAME_CLKS  = `FROUND_H_TOTAL * `FROUND_V_TOTAL * 2;
    localparam int CYCLE_LIMIT = 2 * FRAME_CLKS + 5000;

    logic                       clk;
    logic                       arst_n;
    logic                       pxl_cen;
    logic                       flip;
    logic                       snd_ack;
    logic [1:0]                 debug_sel;
    logic [`FROUND_DUMP_AW-1:0] dump_addr;
    wb_req_t                    wb_req;
    wb_rsp_t                    wb_rsp;
    status_t                    snd_latch;
    status_t                    debug_view;
    status_t                    dump_dout;
    tile_addr_t                 scra_addr;
    tile_addr_t                 scrb_addr;
    logic                       snd_irq;
    logic                       lhbl;
    logic                       lvbl;
    logic                       hs;
    logic                       vs;
    logic [15:0]                lfsr_state;
    int                         cycles;

    fround_game fround_game_i (.*);

    fround_checker u_check (.*);

    // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val = {val[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One classic cycle, snd_ack may ride along on the accepting edge
    task automatic bus_access(input logic we, input int adr, input reg_data_t dat,
                              input logic ack_edge);
        int waited;
        waited = 0;
        wb_req = '{1'b1, 1'b1, we, reg_addr_t'(adr), dat};
        snd_ack = ack_edge;
        do begin
            idle(1);
            snd_ack = 1'b0;
            waited++;
        end while (!wb_rsp.ack && waited < 4);
        if (!wb_rsp.ack) begin
            u_check.report_error($sformatf("no ack for register %0d within 4 clocks", adr));
        end
        wb_req = '0;
        idle(1);
        if (wb_rsp.ack) begin
            u_check.report_error($sformatf("ack for register %0d held past one clock", adr));
        end
    endtask

    task automatic write_reg(input int adr, input reg_data_t dat);
        bus_access(1'b1, adr, dat, 1'b0);
    endtask

    task automatic read_reg(input int adr);
        bus_access(1'b0, adr, 8'h00, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #1 pxl_cen = ~pxl_cen;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [15:0] r;
        int          i;
        arst_n     = 1'b0;
        flip       = 1'b0;
        snd_ack    = 1'b0;
        debug_sel  = 2'd0;
        dump_addr  = '0;
        wb_req     = '0;
        lfsr_state = 16'd29;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;

        u_check.begin_test("video_timing");
        idle(FRAME_CLKS);
        u_check.end_test();

        u_check.begin_test("reg_dump");
        for (i = 0; i <= 10; i++) begin
            take_bits(8, r);
            write_reg(i, r[7:0]);
        end
        for (i = 0; i < 16; i++) begin
            dump_addr = 4'(i);
            idle(1);
        end
        idle(1);
        u_check.end_test();

        u_check.begin_test("bus_read");
        for (i = 0; i <= 12; i++) begin
            read_reg(i);
        end
        u_check.end_test();

        u_check.begin_test("sound_latch");
        take_bits(8, r);
        write_reg(11, r[7:0]);
        read_reg(11);
        read_reg(12);
        snd_ack = 1'b1;
        idle(1);
        snd_ack = 1'b0;
        read_reg(12);
        // Write and acknowledge on the same edge
        take_bits(8, r);
        bus_access(1'b1, 11, r[7:0], 1'b1);
        read_reg(12);
        snd_ack = 1'b1;
        idle(1);
        snd_ack = 1'b0;
        idle(1);
        u_check.end_test();

        u_check.begin_test("scroll_addr");
        repeat (4) begin
            for (i = 0; i <= 6; i++) begin
                take_bits(8, r);
                write_reg(i, r[7:0]);
            end
            take_bits(1, r);
            flip = r[0];
            idle(200);
        end
        u_check.end_test();

        u_check.begin_test("debug_view");
        for (i = 0; i < 4; i++) begin
            debug_sel = 2'(i);
            // Unmapped register, only the write count moves
            write_reg(13, 8'h00);
            flip = ~flip;
            idle(3);
        end
        u_check.end_test();

        $display("summary: %0d tests clean, %0d tests with errors",
                 u_check.tests_ok, u_check.tests_bad);
        if (u_check.err_total == 0 && u_check.tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/fround_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fround_defines.svh"

module fround_checker (
    input wire                                clk,
    input wire                                arst_n,
    input wire                                pxl_cen,
    input wire                                flip,
    input wire                                snd_ack,
    input wire fround_bus_pkg::wb_req_t       wb_req,
    input wire fround_bus_pkg::wb_rsp_t       wb_rsp,
    input wire [1:0]                          debug_sel,
    input wire [`FROUND_DUMP_AW-1:0]          dump_addr,
    input wire fround_video_pkg::status_t     snd_latch,
    input wire                                snd_irq,
    input wire                                lhbl,
    input wire                                lvbl,
    input wire                                hs,
    input wire                                vs,
    input wire fround_video_pkg::tile_addr_t  scra_addr,
    input wire fround_video_pkg::tile_addr_t  scrb_addr,
    input wire fround_video_pkg::status_t     debug_view,
    input wire fround_video_pkg::status_t     dump_dout
);

    import fround_bus_pkg::*;
    import fround_video_pkg::*;

    // Register bytes 0 to 10 as the CPU last wrote them
    reg_data_t  regs [0:10];
    status_t    m_latch;
    status_t    m_wr_cnt;
    status_t    m_dump;
    status_t    m_dbg;
    reg_data_t  m_rdat;
    logic       m_irq;
    logic       m_ack;
    logic       m_run;
    logic       new_cyc;
    logic       fx;
    logic       fy;
    hcnt_t      m_h;
    vcnt_t      m_v;
    tile_addr_t m_addr_a;
    tile_addr_t m_addr_b;

    string test_name = "reset";
    int    test_errs = 0;
    int    err_total = 0;
    int    tests_ok = 0;
    int    tests_bad = 0;

    // 64 tiles of 8 pixels per map row, map rows of 64 entries
    function automatic tile_addr_t addr_ref(input logic [3:0] bank, input int h, input int v,
                                            input int sx, input int sy, input logic xf,
                                            input logic yf);
        int x;
        int y;
        x = (h + sx) % 512;
        y = (v + sy) % 512;
        if (xf) begin
            x = 511 - x;
        end
        if (yf) begin
            y = 511 - y;
        end
        return tile_addr_t'(int'(bank) * 4096 + (y / 8) * 64 + x / 8);
    endfunction

    // Scroll bit 8 sits in the flags byte at the register's own index
    function automatic int scroll_val(input int idx);
        return int'({regs[4][idx], regs[idx]});
    endfunction

    function automatic status_t dump_ref(input logic [3:0] a);
        if (a > 4'd10) begin
            return '0;
        end else if (a == 4'd8 || a == 4'd10) begin
            return regs[a] & 8'h03;
        end
        return regs[a];
    endfunction

    function automatic reg_data_t read_ref(input reg_addr_t a);
        if (a == REG_SND_LATCH) begin
            return m_latch;
        end else if (a == REG_STATUS) begin
            return {7'd0, m_irq};
        end
        return '0;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            test_errs++;
            err_total++;
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        test_errs++;
        err_total++;
        $display("ERROR %s %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s failed with %0d errors", test_name, test_errs);
        end
    endtask

    // Outputs settle after the rising edge, inputs for the next edge are already applied
    always @(negedge clk) begin
        if (!arst_n) begin
            foreach (regs[i]) begin
                regs[i] = '0;
            end
            m_latch  = '0;
            m_wr_cnt = '0;
            m_dump   = '0;
            m_dbg    = '0;
            m_rdat   = '0;
            m_irq    = 1'b0;
            m_ack    = 1'b0;
            m_run    = 1'b0;
            m_h      = '0;
            m_v      = '0;
            m_addr_a = '0;
            m_addr_b = '0;
        end else begin
            check("ack", 32'(m_ack), 32'(wb_rsp.ack));
            check("read data", 32'(m_rdat), 32'(wb_rsp.dat));
            check("snd_irq", 32'(m_irq), 32'(snd_irq));
            check("snd_latch", 32'(m_latch), 32'(snd_latch));
            check("lhbl", 32'(m_run && int'(m_h) < `FROUND_H_ACTIVE), 32'(lhbl));
            check("lvbl", 32'(m_run && int'(m_v) < `FROUND_V_ACTIVE), 32'(lvbl));
            check("hs", 32'(int'(m_h) >= `FROUND_HS_START && int'(m_h) < `FROUND_HS_END),
                  32'(hs));
            check("vs", 32'(int'(m_v) >= `FROUND_VS_START && int'(m_v) < `FROUND_VS_END),
                  32'(vs));
            check("scra_addr", 32'(m_addr_a), 32'(scra_addr));
            check("scrb_addr", 32'(m_addr_b), 32'(scrb_addr));
            check("dump_dout", 32'(m_dump), 32'(dump_dout));
            check("debug_view", 32'(m_dbg), 32'(debug_view));

            // Next state, everything from the values before the edge
            new_cyc = wb_req.cyc && wb_req.stb && !m_ack;
            fx = flip ^ regs[4][6];
            fy = flip ^ regs[4][7];
            case (debug_sel)
                2'd0:    m_dbg = m_wr_cnt;
                2'd1:    m_dbg = m_v[7:0];
                2'd2:    m_dbg = m_latch;
                default: m_dbg = {7'd0, flip};
            endcase
            m_dump = dump_ref(dump_addr);
            if (pxl_cen) begin
                m_addr_a = addr_ref(regs[5][3:0], int'(m_h), int'(m_v),
                                    scroll_val(0), scroll_val(2), fx, fy);
                m_addr_b = addr_ref(regs[6][3:0], int'(m_h), int'(m_v),
                                    scroll_val(1), scroll_val(3), fx, fy);
            end
            m_rdat = (new_cyc && !wb_req.we) ? read_ref(wb_req.adr) : '0;
            if (new_cyc && wb_req.we && wb_req.adr == REG_SND_LATCH) begin
                m_latch = wb_req.dat;
                m_irq   = 1'b1;
            end else if (snd_ack) begin
                m_irq = 1'b0;
            end
            if (new_cyc && wb_req.we) begin
                m_wr_cnt = m_wr_cnt + 8'd1;
                if (wb_req.adr <= REG_OBJ_DY_HI) begin
                    regs[wb_req.adr] = wb_req.dat;
                end
            end
            m_ack = new_cyc;
            m_run = 1'b1;
            if (pxl_cen) begin
                if (int'(m_h) == `FROUND_H_TOTAL - 1) begin
                    m_h = '0;
                    m_v = (int'(m_v) == `FROUND_V_TOTAL - 1) ? '0 : m_v + 9'd1;
                end else begin
                    m_h = m_h + 9'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/fround_game.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fround_defines.svh"

module fround_game (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               pxl_cen,
    input  wire                               flip,
    input  wire fround_bus_pkg::wb_req_t      wb_req,
    input  wire                               snd_ack,
    input  wire [1:0]                         debug_sel,
    input  wire [`FROUND_DUMP_AW-1:0]         dump_addr,
    output fround_bus_pkg::wb_rsp_t           wb_rsp,
    output fround_video_pkg::status_t         snd_latch,
    output logic                              snd_irq,
    output logic                              lhbl,
    output logic                              lvbl,
    output logic                              hs,
    output logic                              vs,
    output fround_video_pkg::tile_addr_t      scra_addr,
    output fround_video_pkg::tile_addr_t      scrb_addr,
    output fround_video_pkg::status_t         debug_view,
    output fround_video_pkg::status_t         dump_dout
);

    import fround_video_pkg::*;

    video_ctrl_t vctrl;
    video_pos_t  pos;
    status_t     st_regs;
    status_t     st_video;

    assign st_video = pos.v[7:0];
    assign lhbl     = pos.lhbl;
    assign lvbl     = pos.lvbl;
    assign hs       = pos.hs;
    assign vs       = pos.vs;

    fround_ctrl_regs u_regs (
        .clk        ( clk         ),
        .arst_n     ( arst_n      ),
        .wb_req     ( wb_req      ),
        .snd_ack    ( snd_ack     ),
        .wb_rsp     ( wb_rsp      ),
        .vctrl      ( vctrl       ),
        .snd_latch  ( snd_latch   ),
        .snd_irq    ( snd_irq     ),
        .st_dout    ( st_regs     )
    );

    fround_video_timing u_timing (
        .clk        ( clk         ),
        .arst_n     ( arst_n      ),
        .pxl_cen    ( pxl_cen     ),
        .pos        ( pos         )
    );

    fround_scroll_addr u_scroll (
        .clk        ( clk         ),
        .arst_n     ( arst_n      ),
        .pxl_cen    ( pxl_cen     ),
        .pos        ( pos         ),
        .vctrl      ( vctrl       ),
        .flip       ( flip        ),
        .scra_addr  ( scra_addr   ),
        .scrb_addr  ( scrb_addr   )
    );

    // Sound status is the latch itself
    fround_debug_view u_debug (
        .clk        ( clk         ),
        .arst_n     ( arst_n      ),
        .debug_sel  ( debug_sel   ),
        .st_regs    ( st_regs     ),
        .st_video   ( st_video    ),
        .st_snd     ( snd_latch   ),
        .flip       ( flip        ),
        .dump_addr  ( dump_addr   ),
        .vctrl      ( vctrl       ),
        .debug_view ( debug_view  ),
        .dump_dout  ( dump_dout   )
    );

endmodule

`default_nettype wire

/* src/fround_debug_view.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fround_defines.svh"

module fround_debug_view (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire [1:0]                            debug_sel,
    input  wire fround_video_pkg::status_t       st_regs,
    input  wire fround_video_pkg::status_t       st_video,
    input  wire fround_video_pkg::status_t       st_snd,
    input  wire                                  flip,
    input  wire [`FROUND_DUMP_AW-1:0]            dump_addr,
    input  wire fround_video_pkg::video_ctrl_t   vctrl,
    output fround_video_pkg::status_t            debug_view,
    output fround_video_pkg::status_t            dump_dout
);

    import fround_bus_pkg::*;
    import fround_video_pkg::*;

    status_t dump_byte;

    // Same byte layout as the CPU writes it
    always_comb begin
        case (dump_addr)
            REG_SCRA_X:    dump_byte = vctrl.scra_x[7:0];
            REG_SCRB_X:    dump_byte = vctrl.scrb_x[7:0];
            REG_SCRA_Y:    dump_byte = vctrl.scra_y[7:0];
            REG_SCRB_Y:    dump_byte = vctrl.scrb_y[7:0];
            REG_FLAGS:     dump_byte = {vctrl.vflip, vctrl.hflip, vctrl.prio,
                                        vctrl.scrb_y[8], vctrl.scra_y[8],
                                        vctrl.scrb_x[8], vctrl.scra_x[8]};
            REG_BANK_LO:   dump_byte = vctrl.scr_bank[7:0];
            REG_BANK_HI:   dump_byte = vctrl.scr_bank[15:8];
            REG_OBJ_DX_LO: dump_byte = vctrl.obj_dx[7:0];
            REG_OBJ_DX_HI: dump_byte = {6'd0, vctrl.obj_dx[9:8]};
            REG_OBJ_DY_LO: dump_byte = vctrl.obj_dy[7:0];
            REG_OBJ_DY_HI: dump_byte = {6'd0, vctrl.obj_dy[9:8]};
            default:       dump_byte = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dump_dout  <= '0;
            debug_view <= '0;
        end else begin
            dump_dout <= dump_byte;
            case (debug_sel)
                2'd0:    debug_view <= st_regs;
                2'd1:    debug_view <= st_video;
                2'd2:    debug_view <= st_snd;
                default: debug_view <= {7'd0, flip};
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/fround_scroll_addr.sv */
`timescale 1ns/1ps
`default_nettype none

module fround_scroll_addr (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire                                  pxl_cen,
    input  wire fround_video_pkg::video_pos_t    pos,
    input  wire fround_video_pkg::video_ctrl_t   vctrl,
    input  wire                                  flip,
    output fround_video_pkg::tile_addr_t         scra_addr,
    output fround_video_pkg::tile_addr_t         scrb_addr
);

    import fround_video_pkg::*;

    logic flip_x;
    logic flip_y;

    // Same address rule for both layers
    function automatic tile_addr_t layer_addr(
        input logic [3:0] bank,
        input hcnt_t      h,
        input vcnt_t      v,
        input scroll_t    scr_x,
        input scroll_t    scr_y,
        input logic       fx,
        input logic       fy
    );
        scroll_t x;
        scroll_t y;
        x = h + scr_x;
        y = v + scr_y;
        if (fx) x = ~x;
        if (fy) y = ~y;
        // 8x8 tiles, so the low three bits drop out
        return {bank, y[8:3], x[8:3]};
    endfunction

    assign flip_x = flip ^ vctrl.hflip;
    assign flip_y = flip ^ vctrl.vflip;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scra_addr <= '0;
            scrb_addr <= '0;
        end else if (pxl_cen) begin
            scra_addr <= layer_addr(vctrl.scr_bank[3:0], pos.h, pos.v,
                                    vctrl.scra_x, vctrl.scra_y, flip_x, flip_y);
            scrb_addr <= layer_addr(vctrl.scr_bank[11:8], pos.h, pos.v,
                                    vctrl.scrb_x, vctrl.scrb_y, flip_x, flip_y);
        end
    end

endmodule

`default_nettype wire

/* src/fround_video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fround_defines.svh"

module fround_video_timing (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              pxl_cen,
    output fround_video_pkg::video_pos_t     pos
);

    import fround_video_pkg::*;

    hcnt_t h_cnt;
    vcnt_t v_cnt;
    logic  running;

    // Keeps blanking low until the first clock out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_cnt == hcnt_t'(`FROUND_H_TOTAL - 1)) begin
                h_cnt <= '0;
                // Line done
                if (v_cnt == vcnt_t'(`FROUND_V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        pos.h    = h_cnt;
        pos.v    = v_cnt;
        pos.lhbl = running && (h_cnt < hcnt_t'(`FROUND_H_ACTIVE));
        pos.lvbl = running && (v_cnt < vcnt_t'(`FROUND_V_ACTIVE));
        pos.hs   = (h_cnt >= hcnt_t'(`FROUND_HS_START)) && (h_cnt < hcnt_t'(`FROUND_HS_END));
        pos.vs   = (v_cnt >= vcnt_t'(`FROUND_VS_START)) && (v_cnt < vcnt_t'(`FROUND_VS_END));
    end

endmodule

`default_nettype wire

/* src/fround_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fround_ctrl_regs (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire fround_bus_pkg::wb_req_t      wb_req,
    input  wire                               snd_ack,
    output fround_bus_pkg::wb_rsp_t           wb_rsp,
    output fround_video_pkg::video_ctrl_t     vctrl,
    output fround_video_pkg::status_t         snd_latch,
    output logic                              snd_irq,
    output fround_video_pkg::status_t         st_dout
);

    import fround_bus_pkg::*;
    import fround_video_pkg::*;

    logic      cyc_new;
    logic      wr_en;
    reg_data_t rd_dat;
    status_t   wr_cnt;

    // Ack goes out once per cycle, one clock after the request shows up
    assign cyc_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_en   = cyc_new && wb_req.we;

    // Only the latch and the status byte read back
    always_comb begin
        case (wb_req.adr)
            REG_SND_LATCH: rd_dat = snd_latch;
            REG_STATUS:    rd_dat = {7'd0, snd_irq};
            default:       rd_dat = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= cyc_new;
            wb_rsp.dat <= (cyc_new && !wb_req.we) ? rd_dat : '0;
        end
    end

    // Write-only video registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vctrl <= '0;
        end else if (wr_en) begin
            case (wb_req.adr)
                REG_SCRA_X:    vctrl.scra_x[7:0]     <= wb_req.dat;
                REG_SCRB_X:    vctrl.scrb_x[7:0]     <= wb_req.dat;
                REG_SCRA_Y:    vctrl.scra_y[7:0]     <= wb_req.dat;
                REG_SCRB_Y:    vctrl.scrb_y[7:0]     <= wb_req.dat;
                REG_FLAGS: begin
                    vctrl.vflip     <= wb_req.dat[7];
                    vctrl.hflip     <= wb_req.dat[6];
                    vctrl.prio      <= wb_req.dat[5:4];
                    vctrl.scrb_y[8] <= wb_req.dat[3];
                    vctrl.scra_y[8] <= wb_req.dat[2];
                    vctrl.scrb_x[8] <= wb_req.dat[1];
                    vctrl.scra_x[8] <= wb_req.dat[0];
                end
                REG_BANK_LO:   vctrl.scr_bank[7:0]   <= wb_req.dat;
                REG_BANK_HI:   vctrl.scr_bank[15:8]  <= wb_req.dat;
                REG_OBJ_DX_LO: vctrl.obj_dx[7:0]     <= wb_req.dat;
                REG_OBJ_DX_HI: vctrl.obj_dx[9:8]     <= wb_req.dat[1:0];
                REG_OBJ_DY_LO: vctrl.obj_dy[7:0]     <= wb_req.dat;
                REG_OBJ_DY_HI: vctrl.obj_dy[9:8]     <= wb_req.dat[1:0];
                default: ;
            endcase
        end
    end

    // Sound command latch, a new command beats the acknowledge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else if (wr_en && wb_req.adr == REG_SND_LATCH) begin
            snd_latch <= wb_req.dat;
            snd_irq   <= 1'b1;
        end else if (snd_ack) begin
            snd_irq   <= 1'b0;
        end
    end

    // Accepted writes, wraps at 256
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_cnt <= '0;
        end else if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    assign st_dout = wr_cnt;

endmodule

`default_nettype wire

/* src/fround_video_pkg.sv */
`default_nettype none

package fround_video_pkg;

    typedef logic [8:0]  scroll_t;
    typedef logic [9:0]  obj_ofs_t;
    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;
    typedef logic [15:0] tile_addr_t;
    typedef logic [7:0]  status_t;

    // Everything the CPU sets up for the video side
    typedef struct packed {
        scroll_t     scra_x;
        scroll_t     scra_y;
        scroll_t     scrb_x;
        scroll_t     scrb_y;
        logic [15:0] scr_bank;
        obj_ofs_t    obj_dx;
        obj_ofs_t    obj_dy;
        logic [1:0]  prio;
        logic        hflip;
        logic        vflip;
    } video_ctrl_t;

    // Beam position with its blanking and sync
    typedef struct packed {
        hcnt_t h;
        vcnt_t v;
        logic  lhbl;
        logic  lvbl;
        logic  hs;
        logic  vs;
    } video_pos_t;

endpackage

`default_nettype wire

/* src/fround_bus_pkg.sv */
`default_nettype none

`include "fround_defines.svh"

package fround_bus_pkg;

    typedef logic [`FROUND_REG_AW-1:0] reg_addr_t;
    typedef logic [7:0]                reg_data_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        reg_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        reg_data_t dat;
    } wb_rsp_t;

    // Register map of the main CPU
    localparam reg_addr_t REG_SCRA_X    = 4'd0;
    localparam reg_addr_t REG_SCRB_X    = 4'd1;
    localparam reg_addr_t REG_SCRA_Y    = 4'd2;
    localparam reg_addr_t REG_SCRB_Y    = 4'd3;
    localparam reg_addr_t REG_FLAGS     = 4'd4;
    localparam reg_addr_t REG_BANK_LO   = 4'd5;
    localparam reg_addr_t REG_BANK_HI   = 4'd6;
    localparam reg_addr_t REG_OBJ_DX_LO = 4'd7;
    localparam reg_addr_t REG_OBJ_DX_HI = 4'd8;
    localparam reg_addr_t REG_OBJ_DY_LO = 4'd9;
    localparam reg_addr_t REG_OBJ_DY_HI = 4'd10;
    localparam reg_addr_t REG_SND_LATCH = 4'd11;
    localparam reg_addr_t REG_STATUS    = 4'd12;

endpackage

`default_nettype wire

/* src/fround_defines.svh */
`ifndef FROUND_DEFINES_SVH
`define FROUND_DEFINES_SVH

// Horizontal timing in pixels
`define FROUND_H_TOTAL   384
`define FROUND_H_ACTIVE  320
`define FROUND_HS_START  336
`define FROUND_HS_END    368

// Vertical timing in lines
`define FROUND_V_TOTAL   264
`define FROUND_V_ACTIVE  240
`define FROUND_VS_START  244
`define FROUND_VS_END    248

// Register file and dump port address widths
`define FROUND_REG_AW    4
`define FROUND_DUMP_AW   4

`endif
